// File: hw/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

  //////////////////////////////
  // default geometry
  //////////////////////////////

  localparam int unsigned NumWays      = 4;
  localparam int unsigned NumSets      = 16;
  // one data bank per word of a line
  localparam int unsigned WordsPerLine = 4;
  localparam int unsigned TagWidth     = 10;
  localparam int unsigned WordWidth    = 64;

  localparam int unsigned SetWidth = $clog2(NumSets);
  localparam int unsigned OffWidth = $clog2(WordsPerLine);
  localparam int unsigned WayWidth = $clog2(NumWays);
  // signature is {set, tag}
  localparam int unsigned SigWidth = SetWidth + TagWidth;

  //////////////////////////////
  // shared structs
  //////////////////////////////

  typedef struct packed {
    logic                req;
    logic [SetWidth-1:0] set;
    logic [OffWidth-1:0] off;
  } rd_req_t;

  // full line fill, vld clear turns it into an invalidate
  typedef struct packed {
    logic                                   valid;
    logic                                   vld;
    logic [WayWidth-1:0]                    way;
    logic [SetWidth-1:0]                    set;
    logic [TagWidth-1:0]                    tag;
    logic [WordsPerLine-1:0][WordWidth-1:0] line;
  } fill_t;

  typedef struct packed {
    logic                vld;
    logic [TagWidth-1:0] tag;
  } tag_entry_t;

  typedef struct packed {
    logic                hit;
    logic [WayWidth-1:0] way;
    logic [SetWidth-1:0] set;
  } hit_t;

  typedef struct packed {
    logic [SigWidth-1:0] hit_sig;
    logic [SigWidth-1:0] miss_sig;
    logic                miss_outcome;
  } pred_t;

endpackage

`default_nettype wire

// File: hw/way_array.sv
`timescale 1ns/1ns
`default_nettype none

module way_array #(
  parameter int unsigned NumWays = 4,
  parameter int unsigned NumSets = 16,
  parameter type         entry_t = logic
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire logic                       rd_en_i,
  input  wire logic [$clog2(NumSets)-1:0] rd_set_i,
  input  wire logic                       we_i,
  input  wire logic [$clog2(NumSets)-1:0] wr_set_i,
  input  wire logic [$clog2(NumWays)-1:0] wr_way_i,
  input  entry_t                          wr_entry_i,
  output entry_t [NumWays-1:0]            rd_entries_o
);

  // storage, indexed [set][way]
  entry_t [NumSets-1:0][NumWays-1:0] mem_q;
  // all ways of the last read set
  entry_t [NumWays-1:0]              rd_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else if (we_i) begin
      mem_q[wr_set_i][wr_way_i] <= wr_entry_i;
    end
  end

  // synchronous read, output holds while rd_en_i is low
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_q <= '0;
    end else if (rd_en_i) begin
      rd_q <= mem_q[rd_set_i];
    end
  end

  assign rd_entries_o = rd_q;

endmodule

`default_nettype wire

// File: hw/tag_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module tag_lookup #(
  parameter int unsigned NumWays  = dcache_pkg::NumWays,
  parameter int unsigned NumSets  = dcache_pkg::NumSets,
  parameter int unsigned TagWidth = dcache_pkg::TagWidth
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  dcache_pkg::rd_req_t             rd_req_i,
  input  wire logic [TagWidth-1:0]        rd_tag_i,
  input  dcache_pkg::fill_t               fill_i,
  output logic                            rd_ack_o,
  output logic                            rd_en_o,
  output logic [NumWays-1:0]              hit_oh_o,
  output logic [NumWays-1:0]              rd_vld_bits_o,
  output logic [$clog2(NumSets)-1:0]      rd_set_o
);

  import dcache_pkg::*;

  tag_entry_t                     fill_entry;
  tag_entry_t [NumWays-1:0]       tag_rd;
  logic                           cmp_en_q;
  logic [$clog2(NumSets)-1:0]     rd_set_q;

  // a fill always takes the tag array, reads only get the idle cycles
  assign rd_ack_o = rd_req_i.req & ~fill_i.valid;
  assign rd_en_o  = rd_ack_o;

  assign fill_entry = '{vld: fill_i.vld, tag: fill_i.tag};

  way_array #(
    .NumWays (NumWays),
    .NumSets (NumSets),
    .entry_t (tag_entry_t)
  ) u_tag_array (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_en_i      (rd_ack_o),
    .rd_set_i     (rd_req_i.set),
    .we_i         (fill_i.valid),
    .wr_set_i     (fill_i.set),
    .wr_way_i     (fill_i.way),
    .wr_entry_i   (fill_entry),
    .rd_entries_o (tag_rd)
  );

  //////////////////////////////
  // second cycle of the lookup
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmp_en_q <= 1'b0;
    end else begin
      cmp_en_q <= rd_ack_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_ack_o) begin
      rd_set_q <= rd_req_i.set;
    end
  end

  // tag arrives one cycle after the set index
  for (genvar w = 0; w < NumWays; w++) begin : gen_cmp
    assign rd_vld_bits_o[w] = tag_rd[w].vld;
    assign hit_oh_o[w]      = cmp_en_q & tag_rd[w].vld & (tag_rd[w].tag == rd_tag_i);
  end

  assign rd_set_o = rd_set_q;

endmodule

`default_nettype wire

// File: hw/data_banks.sv
`timescale 1ns/1ns
`default_nettype none

module data_banks #(
  parameter int unsigned NumWays      = dcache_pkg::NumWays,
  parameter int unsigned NumSets      = dcache_pkg::NumSets,
  parameter int unsigned WordsPerLine = dcache_pkg::WordsPerLine,
  parameter int unsigned WordWidth    = dcache_pkg::WordWidth
) (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  input  wire logic                            rd_en_i,
  input  wire logic [$clog2(WordsPerLine)-1:0] rd_off_i,
  input  wire logic [$clog2(NumSets)-1:0]      rd_set_i,
  input  dcache_pkg::fill_t                    fill_i,
  output logic [NumWays-1:0][WordWidth-1:0]    way_words_o
);

  localparam int unsigned OffBits = $clog2(WordsPerLine);

  logic [WordsPerLine-1:0][NumWays-1:0][WordWidth-1:0] bank_words;
  logic [OffBits-1:0]                                  rd_off_q;

  // bank k holds word k of every line, all ways side by side
  for (genvar k = 0; k < WordsPerLine; k++) begin : gen_bank
    logic bank_rd_en;

    // only the bank of the requested word is read
    assign bank_rd_en = rd_en_i & (rd_off_i == OffBits'(k));

    way_array #(
      .NumWays (NumWays),
      .NumSets (NumSets),
      .entry_t (logic [WordWidth-1:0])
    ) u_bank (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .rd_en_i      (bank_rd_en),
      .rd_set_i     (rd_set_i),
      .we_i         (fill_i.valid),
      .wr_set_i     (fill_i.set),
      .wr_way_i     (fill_i.way),
      .wr_entry_i   (fill_i.line[k]),
      .rd_entries_o (bank_words[k])
    );
  end

  // remember which bank was read for the next cycle
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_off_q <= rd_off_i;
    end
  end

  assign way_words_o = bank_words[rd_off_q];

endmodule

`default_nettype wire

// File: hw/hit_readout.sv
`timescale 1ns/1ns
`default_nettype none

module hit_readout #(
  parameter int unsigned NumWays   = dcache_pkg::NumWays,
  parameter int unsigned NumSets   = dcache_pkg::NumSets,
  parameter int unsigned WordWidth = dcache_pkg::WordWidth
) (
  input  wire logic [NumWays-1:0]                hit_oh_i,
  input  wire logic [NumWays-1:0][WordWidth-1:0] way_words_i,
  input  wire logic [$clog2(NumSets)-1:0]        rd_set_i,
  output dcache_pkg::hit_t                       hit_o,
  output logic [WordWidth-1:0]                   rd_data_o
);

  localparam int unsigned WayBits = $clog2(NumWays);

  logic [WayBits-1:0] hit_way;

  // one-hot to binary, lowest way wins on a multiple hit
  always_comb begin
    hit_way = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (hit_oh_i[w]) begin
        hit_way = WayBits'(w);
      end
    end
  end

  assign hit_o.hit = |hit_oh_i;
  assign hit_o.way = hit_way;
  assign hit_o.set = rd_set_i;

  // word of way 0 comes out on a miss, the hit flag says it is stale
  assign rd_data_o = way_words_i[hit_way];

endmodule

`default_nettype wire

// File: hw/reuse_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module reuse_tracker #(
  parameter int unsigned NumWays  = dcache_pkg::NumWays,
  parameter int unsigned NumSets  = dcache_pkg::NumSets,
  parameter int unsigned TagWidth = dcache_pkg::TagWidth
) (
  input  wire logic         clk_i,
  input  wire logic         rst_ni,
  input  dcache_pkg::hit_t  hit_i,
  input  dcache_pkg::fill_t fill_i,
  output dcache_pkg::pred_t pred_o
);

  localparam int unsigned SigBits = $clog2(NumSets) + TagWidth;

  logic [NumSets-1:0][NumWays-1:0][SigBits-1:0] sig_q;
  // set when the line was reused since its fill
  logic [NumSets-1:0][NumWays-1:0]              outcome_q;
  logic                                         fill_store;
  logic [SigBits-1:0]                           fill_sig;

  // invalidates leave the tables alone
  assign fill_store = fill_i.valid & fill_i.vld;
  assign fill_sig   = {fill_i.set, fill_i.tag};

  //////////////////////////////
  // table updates
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sig_q     <= '0;
      outcome_q <= '0;
    end else begin
      if (hit_i.hit) begin
        outcome_q[hit_i.set][hit_i.way] <= 1'b1;
      end
      // fill comes last so it wins on the same line
      if (fill_store) begin
        sig_q[fill_i.set][fill_i.way]     <= fill_sig;
        outcome_q[fill_i.set][fill_i.way] <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // predictor report
  //////////////////////////////

  // all values are the state before this cycle's update
  always_comb begin
    pred_o = '0;
    if (hit_i.hit) begin
      pred_o.hit_sig = sig_q[hit_i.set][hit_i.way];
    end
    if (fill_store) begin
      pred_o.miss_sig     = sig_q[fill_i.set][fill_i.way];
      pred_o.miss_outcome = outcome_q[fill_i.set][fill_i.way];
    end
  end

endmodule

`default_nettype wire

// File: hw/dcache_mem.sv
`timescale 1ns/1ns
`default_nettype none

module dcache_mem #(
  parameter int unsigned NumWays      = dcache_pkg::NumWays,
  parameter int unsigned NumSets      = dcache_pkg::NumSets,
  parameter int unsigned WordsPerLine = dcache_pkg::WordsPerLine,
  parameter int unsigned TagWidth     = dcache_pkg::TagWidth,
  parameter int unsigned WordWidth    = dcache_pkg::WordWidth
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // read port, tag one cycle after the request
  input  dcache_pkg::rd_req_t      rd_req_i,
  input  wire logic [TagWidth-1:0] rd_tag_i,
  // line fill, always has priority
  input  dcache_pkg::fill_t        fill_i,
  output logic                     rd_ack_o,
  output dcache_pkg::hit_t         hit_o,
  output logic [NumWays-1:0]       rd_vld_bits_o,
  output logic [WordWidth-1:0]     rd_data_o,
  output dcache_pkg::pred_t        pred_o
);

  logic                                rd_en;
  logic [NumWays-1:0]                  hit_oh;
  logic [$clog2(NumSets)-1:0]          rd_set;
  logic [NumWays-1:0][WordWidth-1:0]   way_words;

  //////////////////////////////
  // lookup and data side by side
  //////////////////////////////

  tag_lookup #(
    .NumWays  (NumWays),
    .NumSets  (NumSets),
    .TagWidth (TagWidth)
  ) u_tag_lookup (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req_i),
    .rd_tag_i      (rd_tag_i),
    .fill_i        (fill_i),
    .rd_ack_o      (rd_ack_o),
    .rd_en_o       (rd_en),
    .hit_oh_o      (hit_oh),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_set_o      (rd_set)
  );

  data_banks #(
    .NumWays      (NumWays),
    .NumSets      (NumSets),
    .WordsPerLine (WordsPerLine),
    .WordWidth    (WordWidth)
  ) u_data_banks (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_en_i     (rd_en),
    .rd_off_i    (rd_req_i.off),
    .rd_set_i    (rd_req_i.set),
    .fill_i      (fill_i),
    .way_words_o (way_words)
  );

  //////////////////////////////
  // readout and reuse tracking
  //////////////////////////////

  hit_readout #(
    .NumWays   (NumWays),
    .NumSets   (NumSets),
    .WordWidth (WordWidth)
  ) u_hit_readout (
    .hit_oh_i    (hit_oh),
    .way_words_i (way_words),
    .rd_set_i    (rd_set),
    .hit_o       (hit_o),
    .rd_data_o   (rd_data_o)
  );

  reuse_tracker #(
    .NumWays  (NumWays),
    .NumSets  (NumSets),
    .TagWidth (TagWidth)
  ) u_reuse_tracker (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .hit_i  (hit_o),
    .fill_i (fill_i),
    .pred_o (pred_o)
  );

endmodule

`default_nettype wire

// File: tb/tb_dcache_mem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dcache_mem;

  import dcache_pkg::*;

  localparam int Period       = 100;
  localparam int DriveDelay   = 10;
  localparam int CheckDelay   = 50;
  localparam int ResetCycles  = 16;
  localparam int WarmupCycles = 24;
  localparam int NumCycles    = 4000;
  localparam int MarginCycles = 200;
  // few tags, so hits are common
  localparam int TagRange     = 6;
  localparam int WatchdogTime = (ResetCycles + NumCycles + MarginCycles) * Period;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  rd_req_t              rd_req_i;
  logic [TagWidth-1:0]  rd_tag_i;
  fill_t                fill_i;
  logic                 rd_ack_o;
  hit_t                 hit_o;
  logic [NumWays-1:0]   rd_vld_bits_o;
  logic [WordWidth-1:0] rd_data_o;
  pred_t                pred_o;

  // reference model, indexed [set][way]
  logic [TagWidth-1:0]  m_tag     [NumSets][NumWays];
  logic                 m_vld     [NumSets][NumWays];
  logic [WordWidth-1:0] m_line    [NumSets][NumWays][WordsPerLine];
  logic [SigWidth-1:0]  m_sig     [NumSets][NumWays];
  logic                 m_outcome [NumSets][NumWays];

  // read accepted in the previous cycle
  logic                 pend_acc;
  logic [SetWidth-1:0]  pend_set;
  logic [OffWidth-1:0]  pend_off;
  logic [TagWidth-1:0]  pend_tag;

  int cycle;
  int n_hits;
  int n_reuse;
  int n_rejects;

  dcache_mem #(
    .NumWays      (NumWays),
    .NumSets      (NumSets),
    .WordsPerLine (WordsPerLine),
    .TagWidth     (TagWidth),
    .WordWidth    (WordWidth)
  ) u_dcache_mem (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .rd_req_i      (rd_req_i),
    .rd_tag_i      (rd_tag_i),
    .fill_i        (fill_i),
    .rd_ack_o      (rd_ack_o),
    .hit_o         (hit_o),
    .rd_vld_bits_o (rd_vld_bits_o),
    .rd_data_o     (rd_data_o),
    .pred_o        (pred_o)
  );

  always #(Period / 2) clk_i = ~clk_i;

  //////////////////////////////
  // error handling and compares
  //////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] %s at cycle %0d: got 0x%0h, expected 0x%0h",
                          name, cycle, act, exp));
    end
  endtask

  task automatic check_bits(input logic [NumWays-1:0] act, input logic [NumWays-1:0] exp);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] rd_vld_bits_o at cycle %0d: got 0x%0h, expected 0x%0h",
                          cycle, act, exp));
    end
  endtask

  // way and set only matter on a hit
  task automatic check_hit(input hit_t act, input hit_t exp);
    if (act.hit !== exp.hit || (exp.hit && (act.way !== exp.way || act.set !== exp.set))) begin
      abort_run($sformatf("[ERROR] hit_o at cycle %0d: got 0x%0h, expected 0x%0h",
                          cycle, act, exp));
    end
  endtask

  task automatic check_word(input logic [WordWidth-1:0] act, input logic [WordWidth-1:0] exp);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] rd_data_o at cycle %0d: got 0x%0h, expected 0x%0h",
                          cycle, act, exp));
    end
  endtask

  task automatic check_pred(input pred_t act, input pred_t exp);
    if (act !== exp) begin
      abort_run($sformatf("[ERROR] pred_o at cycle %0d: got 0x%0h, expected 0x%0h",
                          cycle, act, exp));
    end
  endtask

  //////////////////////////////
  // stimulus and model
  //////////////////////////////

  task automatic reset_model();
    for (int s = 0; s < NumSets; s++) begin
      for (int w = 0; w < NumWays; w++) begin
        m_tag[s][w]     = '0;
        m_vld[s][w]     = 1'b0;
        m_sig[s][w]     = '0;
        m_outcome[s][w] = 1'b0;
        for (int k = 0; k < WordsPerLine; k++) begin
          m_line[s][w][k] = '0;
        end
      end
    end
    pend_acc = 1'b0;
    pend_set = '0;
    pend_off = '0;
    pend_tag = '0;
  endtask

  task automatic drive_inputs(input bit allow_fill);
    fill_t   f;
    rd_req_t r;
    f = '0;
    r = '0;
    if (allow_fill && $urandom_range(99) < 35) begin
      f.valid = 1'b1;
      f.vld   = ($urandom_range(99) < 85);
      f.way   = WayWidth'($urandom_range(NumWays - 1));
      f.set   = SetWidth'($urandom_range(NumSets - 1));
      f.tag   = TagWidth'($urandom_range(TagRange - 1));
      for (int k = 0; k < WordsPerLine; k++) begin
        f.line[k] = WordWidth'({$urandom, $urandom});
      end
    end
    r.req    = ($urandom_range(99) < 60);
    r.set    = SetWidth'($urandom_range(NumSets - 1));
    r.off    = OffWidth'($urandom_range(WordsPerLine - 1));
    fill_i   = f;
    rd_req_i = r;
    // tag phase of the read accepted one cycle earlier
    rd_tag_i = pend_acc ? pend_tag : TagWidth'($urandom_range(TagRange - 1));
  endtask

  task automatic check_outputs(output hit_t exp_hit);
    pred_t              exp_pred;
    logic [NumWays-1:0] exp_vld;
    exp_hit  = '0;
    exp_pred = '0;
    exp_vld  = '0;
    check_flag("rd_ack_o", rd_ack_o, rd_req_i.req & ~fill_i.valid);
    if (rd_req_i.req && fill_i.valid) begin
      n_rejects++;
    end
    if (pend_acc) begin
      exp_hit.set = pend_set;
      // walk down so the lowest matching way is kept
      for (int w = NumWays - 1; w >= 0; w--) begin
        exp_vld[w] = m_vld[pend_set][w];
        if (m_vld[pend_set][w] && m_tag[pend_set][w] == pend_tag) begin
          exp_hit.hit = 1'b1;
          exp_hit.way = WayWidth'(w);
        end
      end
      check_bits(rd_vld_bits_o, exp_vld);
    end
    check_hit(hit_o, exp_hit);
    if (exp_hit.hit) begin
      n_hits++;
      check_word(rd_data_o, m_line[pend_set][exp_hit.way][pend_off]);
      exp_pred.hit_sig = m_sig[pend_set][exp_hit.way];
    end
    if (fill_i.valid && fill_i.vld) begin
      exp_pred.miss_sig     = m_sig[fill_i.set][fill_i.way];
      exp_pred.miss_outcome = m_outcome[fill_i.set][fill_i.way];
      if (exp_pred.miss_outcome) begin
        n_reuse++;
      end
    end
    check_pred(pred_o, exp_pred);
  endtask

  task automatic step_model(input hit_t exp_hit);
    if (exp_hit.hit) begin
      m_outcome[exp_hit.set][exp_hit.way] = 1'b1;
    end
    // a fill of the same line in this cycle overrides the hit
    if (fill_i.valid) begin
      m_tag[fill_i.set][fill_i.way] = fill_i.tag;
      m_vld[fill_i.set][fill_i.way] = fill_i.vld;
      for (int k = 0; k < WordsPerLine; k++) begin
        m_line[fill_i.set][fill_i.way][k] = fill_i.line[k];
      end
      if (fill_i.vld) begin
        m_sig[fill_i.set][fill_i.way]     = {fill_i.set, fill_i.tag};
        m_outcome[fill_i.set][fill_i.way] = 1'b0;
      end
    end
    pend_acc = rd_req_i.req & ~fill_i.valid;
    pend_set = rd_req_i.set;
    pend_off = rd_req_i.off;
    pend_tag = TagWidth'($urandom_range(TagRange - 1));
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin : main_seq
    hit_t seen_hit;
    void'($urandom(32'h1002));
    rst_ni    = 1'b0;
    rd_req_i  = '0;
    rd_tag_i  = '0;
    fill_i    = '0;
    n_hits    = 0;
    n_reuse   = 0;
    n_rejects = 0;
    reset_model();
    repeat (ResetCycles) @(posedge clk_i);
    #(DriveDelay);
    rst_ni = 1'b1;
    // first cycles read only, every lookup must miss
    for (cycle = 0; cycle < NumCycles; cycle++) begin
      @(posedge clk_i);
      #(DriveDelay);
      drive_inputs(cycle >= WarmupCycles);
      #(CheckDelay);
      check_outputs(seen_hit);
      step_model(seen_hit);
    end
    if (n_hits == 0 || n_reuse == 0 || n_rejects == 0) begin
      abort_run($sformatf("stimulus too weak: %0d hits, %0d reused evictions, %0d rejects",
                          n_hits, n_reuse, n_rejects));
    end else begin
      $display("Test OK");
      $finish;
    end
  end

  initial begin : watchdog
    #(WatchdogTime);
    abort_run("watchdog expired before all test cycles were run");
  end

endmodule

`default_nettype wire

// File: compile.f
hw/dcache_pkg.sv
hw/way_array.sv
hw/tag_lookup.sv
hw/data_banks.sv
hw/hit_readout.sv
hw/reuse_tracker.sv
hw/dcache_mem.sv
tb/tb_dcache_mem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache_mem
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Test OK" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
